//--- design/gf_apb_regs.sv
`timescale 1ns/1ps

module gf_apb_regs import gf_pkg::*; #(
	parameter int M = 8
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         psel,
	input  logic         penable,
	input  logic         pwrite,
	input  logic [4:0]   paddr,
	input  logic [31:0]  pwdata,
	output logic [31:0]  prdata,
	output logic         pready,
	output logic         pslverr,
	output gf_cmd_t      cmd,
	output logic [M-1:0] a,
	output logic [M-1:0] b,
	input  logic         busy,
	input  gf_status_t   status,
	input  logic [M-1:0] result
);

	logic access;     // Access phase of a transfer.
	logic addr_ok;
	logic is_ctrl;
	logic ctrl_stall;
	logic complete;   // Transfer ends this cycle.
	logic wr_done;

	assign access  = psel && penable;
	assign is_ctrl = (paddr == REG_CTRL);

	always_comb begin
		case (paddr)
			REG_A, REG_B, REG_CTRL, REG_STATUS, REG_RESULT: addr_ok = 1'b1;
			default:                                        addr_ok = 1'b0;
		endcase
	end

	// A new command waits until the result stage has taken the previous one,
	// so the host always gets to see done of the running operation.
	assign ctrl_stall = access && pwrite && is_ctrl && (busy || status.busy);

	assign pready   = !ctrl_stall;
	assign complete = access && pready;
	assign pslverr  = complete && !addr_ok;
	assign wr_done  = complete && pwrite;

	assign cmd = '{valid: wr_done && is_ctrl, op: gf_op_t'(pwdata[1:0])};

	// Operand registers, truncated to the field width.
	always_ff @(posedge clk) begin
		if (reset) begin
			a <= '0;
			b <= '0;
		end else if (wr_done) begin
			if (paddr == REG_A)
				a <= pwdata[M-1:0];
			if (paddr == REG_B)
				b <= pwdata[M-1:0];
		end
	end

	// Read mux, unused bits stay zero.
	always_comb begin
		prdata = '0;
		case (paddr)
			REG_A:      prdata[M-1:0] = a;
			REG_B:      prdata[M-1:0] = b;
			REG_STATUS: prdata[2:0]   = {status.err, status.done, status.busy};
			REG_RESULT: prdata[M-1:0] = result;
			default:    prdata        = '0; // CTRL is write-only.
		endcase
	end

endmodule

//--- design/gf_arith_top.sv
`timescale 1ns/1ps

module gf_arith_top import gf_pkg::*; #(
	parameter int          M          = 8,
	parameter logic [M-1:0] FIELD_POLY = 8'h1D
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [4:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	gf_cmd_t      cmd;
	gf_status_t   status;
	logic [M-1:0] a;
	logic [M-1:0] b;
	logic [M-1:0] exec_result;
	logic [M-1:0] result;
	logic         busy;
	logic         res_valid;
	logic         res_err;

	gf_apb_regs #(.M(M)) u_regs (
		.clk     (clk),
		.reset   (reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.cmd     (cmd),
		.a       (a),
		.b       (b),
		.busy    (busy),
		.status  (status),
		.result  (result)
	);

	gf_exec #(.M(M), .FIELD_POLY(FIELD_POLY)) u_exec (
		.clk       (clk),
		.reset     (reset),
		.cmd       (cmd),
		.a         (a),
		.b         (b),
		.busy      (busy),
		.result    (exec_result),
		.res_valid (res_valid),
		.res_err   (res_err)
	);

	gf_result #(.M(M)) u_result (
		.clk       (clk),
		.reset     (reset),
		.cmd_valid (cmd.valid),
		.busy      (busy),
		.res_valid (res_valid),
		.res_err   (res_err),
		.res_in    (exec_result),
		.status    (status),
		.result    (result)
	);

endmodule

//--- design/gf_exec.sv
`timescale 1ns/1ps

module gf_exec import gf_pkg::*; #(
	parameter int          M          = 8,
	parameter logic [M-1:0] FIELD_POLY = 'h1D
) (
	input  logic         clk,
	input  logic         reset,
	input  gf_cmd_t      cmd,
	input  logic [M-1:0] a,
	input  logic [M-1:0] b,
	output logic         busy,
	output logic [M-1:0] result,
	output logic         res_valid,
	output logic         res_err
);

	localparam int RW = $clog2(M);

	typedef enum logic [2:0] {
		IDLE,
		SQR,
		MUL,
		INV_SQ,
		INV_MUL,
		FINISH
	} state_t;

	state_t        state;
	logic [M-1:0]  s;         // Current power a^(2^k).
	logic [M-1:0]  s_sq;
	logic [RW-1:0] rnd;       // Inverse rounds still to start.
	logic          mult_start;
	logic [M-1:0]  mult_x;
	logic [M-1:0]  mult_y;
	logic [M-1:0]  mult_p;
	logic          mult_done;
	logic          next_round;

	gf_square #(
		.M          (M),
		.FIELD_POLY (FIELD_POLY)
	) u_square (
		.x (s),
		.y (s_sq)
	);

	gf_serial_mult #(
		.M          (M),
		.FIELD_POLY (FIELD_POLY)
	) u_mult (
		.clk   (clk),
		.reset (reset),
		.start (mult_start),
		.x     (mult_x),
		.y     (mult_y),
		.p     (mult_p),
		.done  (mult_done)
	);

	// Back-to-back inverse rounds, no idle cycle between products.
	assign next_round = (state == IDLE) ? 1'b0
		: ((state == INV_MUL) && mult_done && (rnd != '0));

	// A product starts straight from the command, saving a cycle.
	assign mult_start = ((state == IDLE) && cmd.valid && (cmd.op == OP_MUL))
		|| (state == INV_SQ) || next_round;

	always_comb begin
		case (state)
			IDLE:    mult_x = a;
			INV_SQ:  mult_x = {{(M-1){1'b0}}, 1'b1}; // Running product starts at one.
			default: mult_x = mult_p; // Previous round's product.
		endcase
	end

	assign mult_y = (state == IDLE) ? b : s_sq;
	assign busy   = (state != IDLE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= IDLE;
			rnd       <= '0;
			res_valid <= 1'b0;
			res_err   <= 1'b0;
		end else begin
			res_valid <= 1'b0;
			res_err   <= 1'b0;
			case (state)
				IDLE: begin
					if (cmd.valid) begin
						case (cmd.op)
							OP_MUL:  state <= MUL;
							OP_SQR:  state <= SQR;
							OP_INV:  state <= (a == '0) ? FINISH : INV_SQ;
							default: state <= FINISH;
						endcase
					end
				end
				SQR: begin
					state     <= IDLE;
					res_valid <= 1'b1;
				end
				MUL: begin
					if (mult_done) begin
						state     <= IDLE;
						res_valid <= 1'b1;
					end
				end
				INV_SQ: begin
					state <= INV_MUL;
					rnd   <= RW'(M - 2);
				end
				INV_MUL: begin
					if (next_round) begin
						rnd <= rnd - 1'b1;
					end else if (mult_done) begin
						state     <= IDLE;
						res_valid <= 1'b1;
					end
				end
				FINISH: begin
					state     <= IDLE;
					res_valid <= 1'b1;
					res_err   <= 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (cmd.valid)
					s <= a;
			end
			SQR:     result <= s_sq;
			MUL:     if (mult_done) result <= mult_p;
			INV_SQ:  s <= s_sq;
			INV_MUL: begin
				if (mult_done) begin
					if (next_round)
						s <= s_sq;
					else
						result <= mult_p; // a^(2^M-2).
				end
			end
			FINISH:  result <= '0;
			default: ;
		endcase
	end

endmodule

//--- design/gf_pkg.sv
package gf_pkg;

	// Opcodes in CTRL bits 1:0, value 3 is rejected.
	typedef enum logic [1:0] {
		OP_MUL = 2'd0, // Product a*b.
		OP_SQR = 2'd1, // Square of a.
		OP_INV = 2'd2  // Inverse of a.
	} gf_op_t;

	// Command from the register block to the sequencer.
	typedef struct packed {
		logic   valid; // One-cycle issue pulse.
		gf_op_t op;
	} gf_cmd_t;

	// Status as seen by the host.
	typedef struct packed {
		logic busy;
		logic done; // Sticky until next command.
		logic err;  // Sticky until next command.
	} gf_status_t;

	// APB byte offsets.
	localparam logic [4:0] REG_A      = 5'h00;
	localparam logic [4:0] REG_B      = 5'h04;
	localparam logic [4:0] REG_CTRL   = 5'h08; // Opcode in bits 1:0.
	localparam logic [4:0] REG_STATUS = 5'h0C; // Busy, done, err in bits 0..2.
	localparam logic [4:0] REG_RESULT = 5'h10;

endpackage

//--- design/gf_result.sv
`timescale 1ns/1ps

module gf_result import gf_pkg::*; #(
	parameter int M = 8
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         cmd_valid,
	input  logic         busy,
	input  logic         res_valid,
	input  logic         res_err,
	input  logic [M-1:0] res_in,
	output gf_status_t   status,
	output logic [M-1:0] result
);

	logic busy_q;
	logic done_q;
	logic err_q;

	// Busy is delayed one cycle so it drops together with the rise of done.
	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			err_q  <= 1'b0;
		end else begin
			busy_q <= busy;
			if (cmd_valid) begin
				done_q <= 1'b0;
				err_q  <= 1'b0;
			end else if (res_valid) begin
				done_q <= 1'b1;
				err_q  <= res_err;
			end
		end
	end

	// Last result, read back by the host.
	always_ff @(posedge clk) begin
		if (reset)
			result <= '0;
		else if (res_valid)
			result <= res_in;
	end

	assign status = '{busy: busy_q, done: done_q, err: err_q};

endmodule

//--- design/gf_serial_mult.sv
`timescale 1ns/1ps

module gf_serial_mult #(
	parameter int          M          = 8,
	parameter logic [M-1:0] FIELD_POLY = 'h1D
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         start,
	input  logic [M-1:0] x,
	input  logic [M-1:0] y,
	output logic [M-1:0] p,
	output logic         done
);

	localparam int CW = $clog2(M + 1);

	logic [M-1:0]  x_q;      // Shifts out MSB first.
	logic [M-1:0]  y_q;
	logic [CW-1:0] cnt;      // Steps left.
	logic [M-1:0]  acc_next;

	// Multiply accumulator by alpha, then add y if this bit of x is set.
	assign acc_next = {p[M-2:0], 1'b0}
		^ (p[M-1] ? FIELD_POLY : '0)
		^ (x_q[M-1] ? y_q : '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt  <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				cnt <= CW'(M);
			end else if (cnt != '0) begin
				cnt  <= cnt - 1'b1;
				done <= (cnt == CW'(1)); // Last step.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			x_q <= x;
			y_q <= y;
			p   <= '0;
		end else if (cnt != '0) begin
			x_q <= {x_q[M-2:0], 1'b0};
			p   <= acc_next;
		end
	end

endmodule

//--- design/gf_square.sv
`timescale 1ns/1ps

module gf_square #(
	parameter int          M          = 8,
	parameter logic [M-1:0] FIELD_POLY = 'h1D
) (
	input  logic [M-1:0] x,
	output logic [M-1:0] y
);

	// Bit i of the mask is bit j of x^(2i) mod the field polynomial.
	function automatic logic [M-1:0] sq_mask(input int j);
		logic [M-1:0] pw;
		logic [M-1:0] mask;
		int i;
		int k;
		mask = '0;
		for (i = 0; i < M; i++) begin
			pw = {{(M-1){1'b0}}, 1'b1};
			for (k = 0; k < 2 * i; k++)
				pw = {pw[M-2:0], 1'b0} ^ (pw[M-1] ? FIELD_POLY : '0);
			mask[i] = pw[j];
		end
		return mask;
	endfunction

	// One XOR tree per output bit.
	for (genvar j = 0; j < M; j++) begin : g_bit
		localparam logic [M-1:0] MASK = sq_mask(j);

		assign y[j] = ^(x & MASK);
	end

endmodule

//--- verification/gf_apb_tasks.svh
`ifndef GF_APB_TASKS_SVH
`define GF_APB_TASKS_SVH

task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	if (expected !== actual) begin
		$display("** Error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		$display("Something failed");
		$fatal(1, "Check %s failed", name);
	end
endtask

// One APB transfer, setup cycle then access cycles until pready.
task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err, output int stalls);
	@(negedge clk);
	psel    = 1'b1;
	penable = 1'b0;
	pwrite  = wr;
	paddr   = addr;
	pwdata  = wdata;
	@(negedge clk);
	penable = 1'b1;
	stalls  = 0;
	#(CLK_PERIOD / 4); // Mid low phase, outputs settled.
	while (!pready) begin
		stalls++;
		@(negedge clk);
		#(CLK_PERIOD / 4);
	end
	rdata = prdata;
	err   = pslverr;
	@(negedge clk);
	psel    = 1'b0;
	penable = 1'b0;
endtask

task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
	logic [31:0] rdata;
	logic        err;
	int          stalls;
	apb_xfer(1'b1, addr, data, rdata, err, stalls);
	check($sformatf("write_resp_%0h", addr), 0, err);
endtask

task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
	logic err;
	int   stalls;
	apb_xfer(1'b0, addr, '0, data, err, stalls);
	check($sformatf("read_resp_%0h", addr), 0, err);
endtask

// Reads status until the done bit shows up.
task automatic poll_done(output logic [31:0] st);
	st = '0;
	while (!st[1])
		apb_read(REG_STATUS, st);
endtask

// Polynomial product, LSB first with reduction of the shifted operand.
function automatic logic [M-1:0] ref_mul(input logic [M-1:0] x, input logic [M-1:0] y);
	logic [M-1:0] acc;
	logic [M-1:0] sh;
	acc = '0;
	sh  = x;
	for (int i = 0; i < M; i++) begin
		if (y[i])
			acc = acc ^ sh;
		sh = {sh[M-2:0], 1'b0} ^ (sh[M-1] ? FIELD_POLY : '0);
	end
	return acc;
endfunction

function automatic logic [M-1:0] ref_sqr(input logic [M-1:0] x);
	return ref_mul(x, x);
endfunction

// Brute force search, zero has no inverse.
function automatic logic [M-1:0] ref_inv(input logic [M-1:0] x);
	logic [M-1:0] found;
	found = '0;
	for (int v = 1; v < (1 << M); v++) begin
		if (x != '0 && ref_mul(x, v[M-1:0]) == 1)
			found = v[M-1:0];
	end
	return found;
endfunction

`endif

//--- verification/gf_arith_tb.sv
`timescale 1ns/1ps

module gf_arith_tb import gf_pkg::*; ();

	localparam int           M           = 8;
	localparam logic [M-1:0] FIELD_POLY  = 'h1D;
	localparam int           CLK_PERIOD  = 8;
	localparam int           N_MUL_RAND  = 200;
	localparam int           N_ELEM_RAND = 100;
	// Directed products, random products, three per element, errors and back-pressure.
	localparam int           N_OPS       = 4 + N_MUL_RAND + 3 * N_ELEM_RAND + 5;
	localparam int           INV_LAT     = (M - 1) * (M + 1) + 2;
	localparam int           TIMEOUT_NS  = N_OPS * INV_LAT * CLK_PERIOD * 4;

	logic         clk;
	logic         reset;
	logic         psel;
	logic         penable;
	logic         pwrite;
	logic [4:0]   paddr;
	logic [31:0]  pwdata;
	logic [31:0]  prdata;
	logic         pready;
	logic         pslverr;
	gf_status_t   dut_status;
	logic [M-1:0] dut_result;
	string        exp_name[$]; // Pending operations, oldest first.
	logic [M-1:0] exp_res[$];
	logic         exp_err[$];
	int           done_count;
	logic         done_prev;

	gf_arith_top #(.M(M), .FIELD_POLY(FIELD_POLY)) u_dut (
		.clk     (clk),
		.reset   (reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	`include "gf_apb_tasks.svh"

	assign dut_status = u_dut.status;
	assign dut_result = u_dut.result;

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic expect_result(input string name, input logic [M-1:0] res, input logic err);
		exp_name.push_back(name);
		exp_res.push_back(res);
		exp_err.push_back(err);
	endtask

	// Loads operands, issues the opcode and checks status and result readback.
	task automatic run_op(input string name, input logic [1:0] op, input logic [M-1:0] a,
			input logic [M-1:0] b, output logic [M-1:0] res);
		logic [31:0]  rd;
		logic [M-1:0] exp_r;
		logic         exp_e;
		case (op)
			OP_MUL:  exp_r = ref_mul(a, b);
			OP_SQR:  exp_r = ref_sqr(a);
			OP_INV:  exp_r = ref_inv(a);
			default: exp_r = '0;
		endcase
		exp_e = (op == 2'd3) || (op == OP_INV && a == '0);
		apb_write(REG_A, a);
		apb_write(REG_B, b);
		expect_result(name, exp_r, exp_e);
		apb_write(REG_CTRL, op);
		poll_done(rd);
		check({name, "_status"}, {exp_e, 2'b10}, rd);
		apb_read(REG_RESULT, rd);
		check(name, exp_r, rd);
		res = rd[M-1:0];
	endtask

	function automatic logic [M-1:0] rand_nonzero();
		logic [M-1:0] v;
		v = '0;
		while (v == '0)
			v = $urandom;
		return v;
	endfunction

	// Compares each finished operation with the oldest pending expectation.
	always @(negedge clk) begin : compare_results
		logic rise;
		rise      = !reset && dut_status.done && !done_prev;
		done_prev = !reset && dut_status.done;
		if (rise && exp_name.size() == 0) begin
			$display("An operation finished while no command was pending");
			$display("Something failed");
			$fatal(1, "Unexpected done");
		end else if (rise) begin
			done_count++;
			check({exp_name[0], "_done"}, exp_res.pop_front(), dut_result);
			check({exp_name.pop_front(), "_err"}, exp_err.pop_front(), dut_status.err);
		end
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("Run timed out after %0d ns", TIMEOUT_NS);
		$display("Something failed");
		$fatal(1, "Timeout");
	end

	initial begin : stimulus
		logic [31:0]  rd;
		logic         err;
		int           stalls;
		int           count_before;
		logic [M-1:0] x;
		logic [M-1:0] y;
		logic [M-1:0] inv;
		void'($urandom(53113));
		clk        = 1'b0;
		reset      = 1'b1;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		done_count = 0;
		done_prev  = 1'b0;
		repeat (5) @(negedge clk);
		reset = 1'b0;

		apb_read(REG_STATUS, rd);
		check("reset_status", 0, rd);
		apb_read(REG_RESULT, rd);
		check("reset_result", 0, rd);

		x = rand_nonzero();
		run_op("mul_zero", OP_MUL, '0, x, y);
		run_op("mul_one", OP_MUL, 1, x, y);
		run_op("mul_alpha", OP_MUL, 2, {1'b1, {(M-1){1'b0}}}, y); // Gives alpha^M.
		run_op("mul_ones", OP_MUL, '1, '1, y);
		for (int i = 0; i < N_MUL_RAND; i++) begin
			x = $urandom;
			y = $urandom;
			run_op($sformatf("mul_rand_%0d", i), OP_MUL, x, y, y);
		end

		for (int i = 0; i < N_ELEM_RAND; i++) begin
			x = rand_nonzero();
			run_op($sformatf("sqr_%0d", i), OP_SQR, x, '0, y);
			run_op($sformatf("inv_%0d", i), OP_INV, x, '0, inv);
			run_op($sformatf("inv_prod_%0d", i), OP_MUL, inv, x, y);
			check($sformatf("inv_prod_one_%0d", i), 1, y);
		end

		run_op("inv_zero", OP_INV, '0, '0, y);
		run_op("bad_opcode", 2'd3, rand_nonzero(), '0, y);
		x = rand_nonzero();
		apb_write(REG_A, x);
		expect_result("clear_flags", ref_inv(x), 1'b0);
		apb_write(REG_CTRL, OP_INV);
		apb_read(REG_STATUS, rd);
		check("clear_flags_busy", 1, rd); // Busy only, done and err gone.
		poll_done(rd);
		check("clear_flags_done", 2, rd);

		x = rand_nonzero();
		y = rand_nonzero();
		apb_write(REG_A, x);
		apb_write(REG_B, y);
		expect_result("bp_inv", ref_inv(x), 1'b0);
		apb_write(REG_CTRL, OP_INV);
		count_before = done_count;
		expect_result("bp_mul", ref_mul(x, y), 1'b0);
		apb_xfer(1'b1, REG_CTRL, OP_MUL, rd, err, stalls);
		check("bp_stalled", 1, stalls > 0);
		check("bp_done_before_issue", count_before + 1, done_count);
		check("bp_write_resp", 0, err);
		poll_done(rd);
		apb_read(REG_RESULT, rd);
		check("bp_mul_result", ref_mul(x, y), rd);
		apb_xfer(1'b0, 5'h14, '0, rd, err, stalls);
		check("unmapped_read_err", 1, err);
		apb_xfer(1'b1, 5'h1C, 32'h1234, rd, err, stalls);
		check("unmapped_write_err", 1, err);
		apb_read(REG_A, rd);
		check("reg_a_readback", x, rd);

		if (exp_name.size() == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("%0d operations never finished", exp_name.size());
			$display("Something failed");
			$fatal(1, "Pending operations");
		end
	end

endmodule

//--- verilog.f
+incdir+verification
design/gf_pkg.sv
design/gf_square.sv
design/gf_serial_mult.sv
design/gf_apb_regs.sv
design/gf_exec.sv
design/gf_result.sv
design/gf_arith_top.sv
verification/gf_arith_tb.sv
